/* logic/uart_cfg.svh */
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// register offsets on the 4-bit bus address.
`define UART_REG_DATA       4'h8
`define UART_REG_STATUS     4'hc

// status word bit positions.
`define UART_ST_TX_IDLE     0
`define UART_ST_RX_AVAIL    1
`define UART_ST_TXIDLE_IE   3
`define UART_ST_RXAVAIL_IE  4

// bit timing, a bit lasts UART_CLKS_PER_TICK * UART_OVERSAMPLE clk_bus cycles.
`define UART_CLKS_PER_TICK  4
`define UART_OVERSAMPLE     16

`endif

/* logic/uart_pkg.sv */
package uart_pkg;

    // one character on the line.
    typedef logic [7:0] uart_byte_t;

    // register offset and data word of the bus.
    typedef logic [3:0] bus_addr_t;
    typedef logic [31:0] bus_word_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

/* logic/uart_regs.sv */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_regs (
    input  logic                 clk_bus,
    input  logic                 rst_n,
    input  uart_pkg::bus_addr_t  bus_address_i,
    input  uart_pkg::bus_word_t  bus_data_i,
    input  logic                 bus_read_i,
    input  logic                 bus_write_i,
    input  logic                 tx_idle_i,
    input  uart_pkg::uart_byte_t rx_data_i,
    input  logic                 rx_avail_i,
    output uart_pkg::bus_word_t  bus_data_o,
    output logic                 tx_start_o,
    output uart_pkg::uart_byte_t tx_data_o,
    output logic                 rx_clear_o,
    output logic                 irq_o
);
    import uart_pkg::*;

    logic      txidle_ie;
    logic      rxavail_ie;
    bus_word_t status_word;

    // strobes follow the bus level directly, sampled by tx and rx at the edge.
    assign tx_start_o = bus_write_i && (bus_address_i == `UART_REG_DATA);
    assign tx_data_o  = bus_data_i[7:0];
    assign rx_clear_o = bus_read_i && (bus_address_i == `UART_REG_DATA);

    assign irq_o = (rx_avail_i && rxavail_ie) || (tx_idle_i && txidle_ie);

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            txidle_ie  <= 1'b0;
            rxavail_ie <= 1'b1; // rx interrupt on by default.
        end else if (bus_write_i && (bus_address_i == `UART_REG_STATUS)) begin
            txidle_ie  <= bus_data_i[`UART_ST_TXIDLE_IE];
            rxavail_ie <= bus_data_i[`UART_ST_RXAVAIL_IE];
        end
    end

    always_comb begin
        status_word = '0;
        status_word[`UART_ST_TX_IDLE]    = tx_idle_i;
        status_word[`UART_ST_RX_AVAIL]   = rx_avail_i;
        status_word[`UART_ST_TXIDLE_IE]  = txidle_ie;
        status_word[`UART_ST_RXAVAIL_IE] = rxavail_ie;
    end

    always_comb begin
        bus_data_o = '0;
        if (bus_read_i) begin
            case (bus_address_i)
                `UART_REG_DATA:   bus_data_o = {24'h0, rx_data_i};
                `UART_REG_STATUS: bus_data_o = status_word;
                default:          bus_data_o = '0; // unmapped offsets read zero.
            endcase
        end
    end

    // the bus master never issues a read and a write in the same cycle.
    a_bus_rw_excl: assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        !(bus_read_i && bus_write_i)
    );

endmodule

/* logic/uart_baud_gen.sv */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_baud_gen (
    input  logic clk_bus,
    input  logic rst_n,
    output logic baud_tick_o
);
    localparam int unsigned DIV = `UART_CLKS_PER_TICK;
    localparam int unsigned CW  = $clog2(DIV);
    localparam logic [CW-1:0] CNT_LAST = CW'(DIV - 1);

    logic [CW-1:0] div_cnt;

    // free running, both directions share this tick.
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (div_cnt == CNT_LAST) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            baud_tick_o <= 1'b0;
        end else begin
            baud_tick_o <= (div_cnt == CNT_LAST); // one cycle per period.
        end
    end

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_tx (
    input  logic                 clk_bus,
    input  logic                 rst_n,
    input  logic                 baud_tick_i,
    input  logic                 tx_start_i,
    input  uart_pkg::uart_byte_t tx_data_i,
    output logic                 txd_o,
    output logic                 tx_idle_o
);
    import uart_pkg::*;

    localparam int unsigned OS = `UART_OVERSAMPLE;
    localparam int unsigned TW = $clog2(OS);
    localparam logic [TW-1:0] TICK_LAST = TW'(OS - 1);

    tx_state_t     state;
    logic [TW-1:0] tick_cnt;
    logic [2:0]    bit_cnt;
    uart_byte_t    shreg;
    logic          accept;
    logic          bit_end;

    assign accept    = tx_start_i && (state == TX_IDLE); // busy writes are dropped.
    assign bit_end   = baud_tick_i && (tick_cnt == TICK_LAST);
    assign tx_idle_o = (state == TX_IDLE);

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            txd_o    <= 1'b1;
        end else if (accept) begin
            state    <= TX_START;
            tick_cnt <= '0;
            txd_o    <= 1'b0; // start bit.
        end else if (baud_tick_i && (state != TX_IDLE)) begin
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
            if (bit_end) begin
                case (state)
                    TX_START: begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                        txd_o   <= shreg[0];
                    end
                    TX_DATA: begin
                        if (bit_cnt == 3'd7) begin
                            state <= TX_STOP;
                            txd_o <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            txd_o   <= shreg[0];
                        end
                    end
                    default: state <= TX_IDLE; // end of stop bit.
                endcase
            end
        end
    end

    // lsb first, shifted as each bit goes out.
    always_ff @(posedge clk_bus) begin
        if (accept) begin
            shreg <= tx_data_i;
        end else if (bit_end && ((state == TX_START) || (state == TX_DATA))) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

    a_idle_line_high: assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        (state == TX_IDLE) |-> txd_o
    );

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_rx (
    input  logic                 clk_bus,
    input  logic                 rst_n,
    input  logic                 baud_tick_i,
    input  logic                 rxd_i,
    input  logic                 rx_clear_i,
    output uart_pkg::uart_byte_t rx_data_o,
    output logic                 rx_avail_o
);
    import uart_pkg::*;

    localparam int unsigned OS = `UART_OVERSAMPLE;
    localparam int unsigned TW = $clog2(OS);
    localparam logic [TW-1:0] TICK_HALF = TW'(OS / 2 - 1);
    localparam logic [TW-1:0] TICK_LAST = TW'(OS - 1);

    rx_state_t     state;
    logic [TW-1:0] tick_cnt;
    logic [2:0]    bit_cnt;
    uart_byte_t    shreg;
    logic          rxd_meta;
    logic          rxd_sync;
    logic          rxd_prev;
    logic          start_edge;
    logic          mid_bit;
    logic          byte_done;

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign start_edge = rxd_prev && !rxd_sync;
    assign mid_bit    = baud_tick_i && (tick_cnt == TICK_LAST);
    assign byte_done  = mid_bit && (state == RX_STOP) && rxd_sync; // good stop bit.

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (state == RX_IDLE) begin
            tick_cnt <= '0;
            if (start_edge) begin
                state <= RX_START;
            end
        end else if (baud_tick_i) begin
            tick_cnt <= tick_cnt + 1'b1;
            case (state)
                RX_START: begin
                    if (tick_cnt == TICK_HALF) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rxd_sync ? RX_IDLE : RX_DATA; // glitch goes back.
                    end
                end
                RX_DATA: begin
                    if (mid_bit) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (mid_bit) begin
                        state <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_bus) begin
        if (mid_bit && (state == RX_DATA)) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
        if (byte_done) begin
            rx_data_o <= shreg; // overwrites an unread byte.
        end
    end

    // a clear in the completing cycle only removes the old byte.
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            rx_avail_o <= 1'b0;
        end else if (byte_done) begin
            rx_avail_o <= rx_avail_o || !rx_clear_i;
        end else if (rx_clear_i) begin
            rx_avail_o <= 1'b0;
        end
    end

    a_no_rise_on_clear: assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        $rose(rx_avail_o) |-> !$past(rx_clear_i)
    );

endmodule

/* logic/uart_top.sv */
`timescale 1ns/10ps

module uart_top (
    input  logic                clk_bus,
    input  logic                rst_n,
    input  uart_pkg::bus_addr_t bus_address_i,
    input  uart_pkg::bus_word_t bus_data_i,
    input  logic                bus_read_i,
    input  logic                bus_write_i,
    input  logic                rxd_i,
    output uart_pkg::bus_word_t bus_data_o,
    output logic                uart_irq_o,
    output logic                txd_o
);
    import uart_pkg::*;

    logic       baud_tick;
    logic       tx_start;
    uart_byte_t tx_data;
    logic       tx_idle;
    logic       rx_clear;
    uart_byte_t rx_data;
    logic       rx_avail;

    uart_regs u_regs (
        .clk_bus       (clk_bus),
        .rst_n         (rst_n),
        .bus_address_i (bus_address_i),
        .bus_data_i    (bus_data_i),
        .bus_read_i    (bus_read_i),
        .bus_write_i   (bus_write_i),
        .tx_idle_i     (tx_idle),
        .rx_data_i     (rx_data),
        .rx_avail_i    (rx_avail),
        .bus_data_o    (bus_data_o),
        .tx_start_o    (tx_start),
        .tx_data_o     (tx_data),
        .rx_clear_o    (rx_clear),
        .irq_o         (uart_irq_o)
    );

    uart_baud_gen u_baud_gen (
        .clk_bus     (clk_bus),
        .rst_n       (rst_n),
        .baud_tick_o (baud_tick)
    );

    uart_tx u_tx (
        .clk_bus     (clk_bus),
        .rst_n       (rst_n),
        .baud_tick_i (baud_tick),
        .tx_start_i  (tx_start),
        .tx_data_i   (tx_data),
        .txd_o       (txd_o),
        .tx_idle_o   (tx_idle)
    );

    uart_rx u_rx (
        .clk_bus     (clk_bus),
        .rst_n       (rst_n),
        .baud_tick_i (baud_tick),
        .rxd_i       (rxd_i),
        .rx_clear_i  (rx_clear),
        .rx_data_o   (rx_data),
        .rx_avail_o  (rx_avail)
    );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
    output logic clk_bus_o,
    output logic rst_n_o
);

    initial begin
        clk_bus_o = 1'b0;
        forever #50 clk_bus_o = ~clk_bus_o; // 100 ns period.
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_bus_o);
        @(negedge clk_bus_o);
        rst_n_o = 1'b1; // released on a falling edge.
    end

endmodule

/* tests/uart_tb.sv */
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_tb;
    import uart_pkg::*;

    localparam int TIMEOUT_CYCLES = 1000; // longer than one 640 cycle frame.
    localparam int BIT_CYCLES     = `UART_CLKS_PER_TICK * `UART_OVERSAMPLE;

    logic      clk_bus;
    logic      rst_n;
    bus_addr_t bus_address;
    bus_word_t bus_wdata;
    bus_word_t bus_rdata;
    logic      bus_read;
    logic      bus_write;
    logic      uart_irq;
    logic      txd;
    int        n_pass;
    int        n_fail;
    bit        test_ok;
    bit        aborted;

    tb_clock u_clock (
        .clk_bus_o (clk_bus),
        .rst_n_o   (rst_n)
    );

    uart_top uart_top_i (
        .clk_bus       (clk_bus),
        .rst_n         (rst_n),
        .bus_address_i (bus_address),
        .bus_data_i    (bus_wdata),
        .bus_read_i    (bus_read),
        .bus_write_i   (bus_write),
        .rxd_i         (txd), // loopback.
        .bus_data_o    (bus_rdata),
        .uart_irq_o    (uart_irq),
        .txd_o         (txd)
    );

    task automatic report_mismatch(input string name, input bus_word_t exp, input bus_word_t act);
        $display("ERROR %s expected %h actual %h", name, exp, act);
        test_ok = 1'b0;
    endtask

    // every bus task starts and ends on a falling edge.
    task automatic write_reg(input bus_addr_t addr, input bus_word_t data);
        bus_address = addr;
        bus_wdata   = data;
        bus_write   = 1'b1;
        @(negedge clk_bus);
        bus_write   = 1'b0;
    endtask

    task automatic read_reg(input bus_addr_t addr, output bus_word_t data);
        bus_address = addr;
        bus_read    = 1'b1;
        #20;
        data = bus_rdata; // sampled mid low phase.
        @(negedge clk_bus);
        bus_read    = 1'b0;
    endtask

    task automatic poll_status_bit(input int bit_pos, input string name);
        bus_word_t st;
        int        n;
        st = '0;
        n  = 0;
        while (!st[bit_pos] && (n < TIMEOUT_CYCLES)) begin
            read_reg(`UART_REG_STATUS, st);
            n++;
        end
        if (!st[bit_pos]) begin
            $display("TIMEOUT in %s, status bit %0d was never set", name, bit_pos);
            aborted = 1'b1;
        end
    endtask

    // mode 0 checks now, 1 waits for the level, 2 needs the level to hold.
    task automatic check_irq(input string name, input int mode, input logic level);
        int n;
        n = 0;
        #20;
        if (mode == 1) begin
            while ((uart_irq !== level) && (n < TIMEOUT_CYCLES)) begin
                @(negedge clk_bus);
                #20;
                n++;
            end
            if (uart_irq !== level) begin
                $display("TIMEOUT in %s, interrupt never reached level %0b", name, level);
                aborted = 1'b1;
            end
        end else if (mode == 2) begin
            while ((uart_irq === level) && (n < TIMEOUT_CYCLES)) begin
                @(negedge clk_bus);
                #20;
                n++;
            end
            if (uart_irq !== level) report_mismatch(name, {31'h0, level}, {31'h0, uart_irq});
        end else begin
            if (uart_irq !== level) report_mismatch(name, {31'h0, level}, {31'h0, uart_irq});
        end
        @(negedge clk_bus);
    endtask

    task automatic send_and_receive(input string name, input bus_word_t data,
                                    input bus_word_t exp_byte);
        bus_word_t  st;
        bus_word_t  rd;
        uart_byte_t line_byte;
        write_reg(`UART_REG_DATA, data);
        if (txd !== 1'b0) report_mismatch(name, 32'h0, {31'h0, txd}); // start bit.
        read_reg(`UART_REG_STATUS, st);
        if (st[`UART_ST_TX_IDLE] !== 1'b0) report_mismatch(name, 32'h0, {31'h0, st[0]});
        // data bits go out lsb first, each one sampled near its middle.
        repeat (BIT_CYCLES + BIT_CYCLES / 2 - 1) @(negedge clk_bus);
        for (int i = 0; i < 8; i++) begin
            line_byte[i] = txd;
            repeat (BIT_CYCLES) @(negedge clk_bus);
        end
        if (txd !== 1'b1) report_mismatch(name, 32'h1, {31'h0, txd}); // stop bit.
        if ({24'h0, line_byte} !== exp_byte) report_mismatch(name, exp_byte, {24'h0, line_byte});
        poll_status_bit(`UART_ST_RX_AVAIL, name);
        if (aborted) return;
        read_reg(`UART_REG_DATA, rd);
        if (rd !== exp_byte) report_mismatch(name, exp_byte, rd);
        poll_status_bit(`UART_ST_TX_IDLE, name);
        if (aborted) return;
        read_reg(`UART_REG_STATUS, st);
        if (st[`UART_ST_RX_AVAIL] !== 1'b0) begin
            report_mismatch(name, 32'h0, {31'h0, st[`UART_ST_RX_AVAIL]});
        end
    endtask

    initial begin
        int        fd;
        int        n;
        string     line;
        string     name;
        string     op;
        bus_word_t addr;
        bus_word_t data;
        bus_word_t expect_v;
        bus_word_t rd;
        bus_address = '0;
        bus_wdata   = '0;
        bus_read    = 1'b0;
        bus_write   = 1'b0;
        n_pass      = 0;
        n_fail      = 0;
        aborted     = 1'b0;
        n           = 0;
        while (!rst_n && (n < 50)) begin
            @(negedge clk_bus);
            n++;
        end
        if (!rst_n) begin
            $display("reset was never released");
            aborted = 1'b1;
        end
        @(negedge clk_bus);
        fd = $fopen("tests/uart_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/uart_golden.txt");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ((line.len() < 2) || (line.getc(0) == "#")) continue;
            if ($sscanf(line, "%s %s %h %h %h", name, op, addr, data, expect_v) != 5) continue;
            test_ok = 1'b1;
            if (op == "W") begin
                write_reg(addr[3:0], data);
            end else if (op == "R") begin
                read_reg(addr[3:0], rd);
                if (rd !== expect_v) report_mismatch(name, expect_v, rd);
            end else if (op == "I") begin
                check_irq(name, int'(data), expect_v[0]);
            end else if (op == "S") begin
                send_and_receive(name, data, expect_v);
            end else begin
                $display("unknown operation %s in test %s", op, name);
                test_ok = 1'b0;
            end
            if (aborted) test_ok = 1'b0;
            if (test_ok) begin
                n_pass++;
                $display("PASS %s", name);
            end else begin
                n_fail++;
            end
        end
        if (fd != 0) $fclose(fd);
        $display("summary: %0d passed, %0d failed", n_pass, n_fail);
        if ((n_fail == 0) && !aborted && (n_pass > 0)) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* tests/uart_golden.txt */
# columns: test name, op (W write, R read, S send and receive, I interrupt), address, data, expected
# for I the data column is 0 check now, 1 wait for the level, 2 level must hold a frame
reset_status   R c 0   00000011
reset_irq      I 0 0   0
unmapped_0     R 0 0   0
unmapped_4     R 4 0   0
loop_a5        S 8 a5  a5
loop_3c        S 8 3c  3c
loop_00        S 8 00  00
loop_ff        S 8 ff  ff
loop_low_byte  S 8 1a5 a5
ie_txidle      W c 08  0
irq_txidle_hi  I 0 0   1
status_ie      R c 0   00000009
ie_off         W c 00  0
irq_off_lo     I 0 0   0
ie_rxavail     W c 10  0
rx_send        W 8 96  0
irq_rx_wait    I 0 1   1
irq_rx_hold    I 0 0   1
rx_read        R 8 0   96
irq_rx_lo      I 0 0   0
ie_both        W c 18  0
wait_tx_idle   I 0 1   1
ie_rx_only     W c 10  0
busy_first     W 8 c3  0
busy_second    W 8 3e  0
busy_rx_wait   I 0 1   1
busy_read      R 8 0   c3
busy_no_second I 0 2   0
final_status   R c 0   00000011

/* sources.f */
+incdir+logic
logic/uart_pkg.sv
logic/uart_regs.sv
logic/uart_baud_gen.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_top.sv
tests/tb_clock.sv
tests/uart_tb.sv

/* Bender.yml */
package:
  name: uart_periph

sources:
  - include_dirs:
      - logic
    files:
      - logic/uart_pkg.sv
      - logic/uart_regs.sv
      - logic/uart_baud_gen.sv
      - logic/uart_tx.sv
      - logic/uart_rx.sv
      - logic/uart_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_clock.sv
      - tests/uart_tb.sv
